//--- bcast_hub.f
source/bcast_pkg.sv
source/bcast_rr_arb.sv
source/bcast_decode.sv
source/bcast_txn_ctrl.sv
source/bcast_resp_route.sv
source/bcast_hub.sv
dv/bcast_hub_tb.sv

//--- run.sh
#!/bin/sh
# Build the hub testbench with Verilator, run it and scan the log
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal --top-module bcast_hub_tb \
  -f bcast_hub.f -o bcast_hub_sim > build.log 2>&1 || { cat build.log; exit 1; }
./obj_dir/bcast_hub_sim > sim.log 2>&1 ; cat sim.log
grep -q "TB FAILED" sim.log && exit 1 || grep -q "TB PASSED" sim.log

//--- dv/bcast_hub_tb.sv
`timescale 1ns/1ps

module bcast_hub_tb import bcast_pkg::*; ();

  localparam int unsigned MaxWait = 200;

  logic   clk_i;
  logic   rst_ni;
  logic   host_a_valid_i;
  a_msg_t host_a_i;
  logic   host_a_ready_o;
  logic   host_b_valid_o;
  b_msg_t host_b_o;
  logic   host_b_ready_i;
  logic   host_c_valid_i;
  a_msg_t host_c_i;
  logic   host_c_ready_o;
  logic   host_d_valid_o;
  d_msg_t host_d_o;
  logic   host_d_ready_i;
  logic   host_e_valid_i;
  logic   dev_a_valid_o;
  a_msg_t dev_a_o;
  logic   dev_a_ready_i;
  logic   dev_d_valid_i;
  d_msg_t dev_d_i;
  logic   dev_d_ready_o;
  integer seed;

  bcast_hub dut (.*);

  initial begin
    clk_i = 1'b0;
    forever #5 clk_i = ~clk_i;
  end

  //////////////////////////////////////////////////////////////////////
  // Message builders and compares
  //////////////////////////////////////////////////////////////////////

  function automatic a_msg_t a_msg(input a_op_e op, input logic [2:0] param,
      input logic [2:0] size, input logic [31:0] addr, input logic [4:0] src,
      input logic [3:0] mask, input logic [31:0] data);
    a_msg_t m;
    m.opcode  = op;
    m.param   = param;
    m.size    = size;
    m.address = addr;
    m.source  = src;
    m.mask    = mask;
    m.data    = data;
    return m;
  endfunction

  function automatic b_msg_t b_msg(input cap_e param, input logic [31:0] addr,
      input logic [2:0] src);
    b_msg_t m;
    m.param   = param;
    m.address = addr;
    m.source  = src;
    return m;
  endfunction

  function automatic d_msg_t d_msg(input d_op_e op, input logic [2:0] param,
      input logic [4:0] src, input logic [31:0] data);
    d_msg_t m;
    m.opcode = op;
    m.param  = param;
    m.source = src;
    m.data   = data;
    return m;
  endfunction

  task automatic stop_on_error();
    $display("TB FAILED");
    $fatal(1, "Stopping at the first error");
  endtask

  task automatic report_timeout(input string what);
    $display("Timeout while waiting for %s", what);
    stop_on_error();
  endtask

  task automatic check_a(input string name, input a_msg_t got, input a_msg_t exp);
    if (got !== exp) begin
      $display("FAILED at %0t: %s is %h, expected %h", $time, name, got, exp);
      stop_on_error();
    end
  endtask

  task automatic check_b(input string name, input b_msg_t got, input b_msg_t exp);
    if (got !== exp) begin
      $display("FAILED at %0t: %s is %h, expected %h", $time, name, got, exp);
      stop_on_error();
    end
  endtask

  task automatic check_d(input string name, input d_msg_t got, input d_msg_t exp);
    if (got !== exp) begin
      $display("FAILED at %0t: %s is %h, expected %h", $time, name, got, exp);
      stop_on_error();
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("FAILED at %0t: %s is %b, expected %b", $time, name, got, exp);
      stop_on_error();
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Channel drivers and monitors
  //////////////////////////////////////////////////////////////////////

  task automatic drive_a(input a_msg_t msg);
    @(posedge clk_i);
    host_a_valid_i <= 1'b1;
    host_a_i       <= msg;
  endtask

  task automatic drive_c(input a_msg_t msg);
    @(posedge clk_i);
    host_c_valid_i <= 1'b1;
    host_c_i       <= msg;
  endtask

  task automatic drive_dev_d(input d_msg_t msg);
    @(posedge clk_i);
    dev_d_valid_i <= 1'b1;
    dev_d_i       <= msg;
  endtask

  task automatic send_e();
    @(posedge clk_i);
    host_e_valid_i <= 1'b1;
    @(posedge clk_i);
    host_e_valid_i <= 1'b0;
  endtask

  // Each monitor returns on the clock edge that completes the transfer
  task automatic expect_probe(input b_msg_t exp);
    int n;
    n = 0;
    @(negedge clk_i);
    while (!host_b_valid_o) begin
      n++;
      if (n > MaxWait) report_timeout("a probe on host B");
      @(negedge clk_i);
    end
    check_b("host_b_o", host_b_o, exp);
    @(posedge clk_i);
  endtask

  task automatic expect_dev_a(input a_msg_t exp, input logic a_done);
    int n;
    n = 0;
    @(negedge clk_i);
    while (!dev_a_valid_o) begin
      n++;
      if (n > MaxWait) report_timeout("a request on device A");
      @(negedge clk_i);
    end
    check_a("dev_a_o", dev_a_o, exp);
    check_bit("host_a_ready_o", host_a_ready_o, a_done);
    // C is taken only in the cycle its own message leaves the hub
    check_bit("host_c_ready_o", host_c_ready_o, host_c_valid_i);
    @(posedge clk_i);
  endtask

  task automatic expect_host_d(input d_msg_t exp, input logic a_done, input int hold);
    int n;
    n = 0;
    @(negedge clk_i);
    while (!host_d_valid_o) begin
      n++;
      if (n > MaxWait) report_timeout("a response on host D");
      @(negedge clk_i);
    end
    check_d("host_d_o", host_d_o, exp);
    check_bit("host_a_ready_o", host_a_ready_o, a_done);
    check_bit("dev_a_valid_o", dev_a_valid_o, 1'b0);
    check_bit("host_c_ready_o", host_c_ready_o, host_c_valid_i);
    // Stalled response has to stay put
    for (int i = 0; i < hold; i++) begin
      @(negedge clk_i);
      check_bit("host_d_valid_o", host_d_valid_o, 1'b1);
      check_bit("dev_d_ready_o", dev_d_ready_o, 1'b0);
      check_d("host_d_o", host_d_o, exp);
    end
    if (hold > 0) begin
      @(posedge clk_i);
      host_d_ready_i <= 1'b1;
      @(negedge clk_i);
      check_d("host_d_o", host_d_o, exp);
    end
    @(posedge clk_i);
  endtask

  task automatic wait_c_accept();
    int n;
    n = 0;
    @(negedge clk_i);
    while (!host_c_ready_o) begin
      n++;
      if (n > MaxWait) report_timeout("host C to be accepted");
      @(negedge clk_i);
    end
    @(posedge clk_i);
    host_c_valid_i <= 1'b0;
  endtask

  // Write-back acks are swallowed by the hub
  task automatic absorb_dev_ack(input d_msg_t msg);
    int n;
    n = 0;
    drive_dev_d(msg);
    @(negedge clk_i);
    while (!dev_d_ready_o) begin
      n++;
      if (n > MaxWait) report_timeout("device D to be accepted");
      @(negedge clk_i);
    end
    check_bit("host_d_valid_o", host_d_valid_o, 1'b0);
    @(posedge clk_i);
    dev_d_valid_i <= 1'b0;
  endtask

  //////////////////////////////////////////////////////////////////////
  // Directed tests
  //////////////////////////////////////////////////////////////////////

  task automatic test_uncached_get();
    logic [DataWidth-1:0] rdata;
    rdata = $random(seed);
    drive_a(a_msg(Get, 3'd0, 3'd2, 32'h0000_1234, 5'd1, 4'hf, '0));
    expect_probe(b_msg(toB, 32'h0000_1200, 3'd4));
    drive_c(a_msg(ProbeAck, toN, 3'd2, 32'h0000_1200, 5'd4, 4'h0, '0));
    wait_c_accept();
    expect_dev_a(a_msg(Get, 3'd0, 3'd2, 32'h0000_1234, {3'd1, XactUncached}, 4'hf, '0),
                 1'b1);
    host_a_valid_i <= 1'b0;
    drive_dev_d(d_msg(AccessAckData, 3'd0, {3'd1, XactUncached}, rdata));
    expect_host_d(d_msg(AccessAckData, 3'd0, 5'd1, rdata), 1'b0, 0);
    dev_d_valid_i <= 1'b0;
  endtask

  task automatic test_acquire_block();
    logic [DataWidth-1:0] cdata;
    logic [DataWidth-1:0] gdata;
    cdata = $random(seed);
    gdata = $random(seed);
    drive_a(a_msg(AcquireBlock, NtoB, 3'd2, 32'h0000_2088, 5'd5, 4'hf, '0));
    expect_probe(b_msg(toB, 32'h0000_2080, 3'd0));
    // Half word at byte 2 lands on the upper lanes
    drive_c(a_msg(ProbeAckData, toN, 3'd1, 32'h0000_2082, 5'd0, 4'h0, cdata));
    expect_dev_a(a_msg(PutFullData, 3'd0, 3'd1, 32'h0000_2082, {3'd5, XactAcqToT},
                       4'b1100, cdata), 1'b0);
    host_c_valid_i <= 1'b0;
    absorb_dev_ack(d_msg(AccessAck, 3'd0, {3'd5, XactAcqToT}, '0));
    expect_dev_a(a_msg(Get, 3'd0, 3'd2, 32'h0000_2088, {3'd5, XactAcqToB}, 4'hf, '0),
                 1'b1);
    host_a_valid_i <= 1'b0;
    drive_dev_d(d_msg(AccessAckData, 3'd0, {3'd5, XactAcqToB}, gdata));
    expect_host_d(d_msg(GrantData, toB, 5'd5, gdata), 1'b0, 0);
    dev_d_valid_i <= 1'b0;
    send_e();
  endtask

  task automatic test_acquire_perm();
    drive_a(a_msg(AcquirePerm, NtoT, 3'd2, 32'h0000_3010, 5'd1, 4'hf, '0));
    expect_probe(b_msg(toN, 32'h0000_3000, 3'd4));
    drive_c(a_msg(ProbeAck, toN, 3'd2, 32'h0000_3000, 5'd4, 4'h0, '0));
    wait_c_accept();
    expect_host_d(d_msg(Grant, toT, 5'd1, '0), 1'b1, 0);
    host_a_valid_i <= 1'b0;
    send_e();
  endtask

  task automatic test_release();
    logic [DataWidth-1:0] wdata;
    wdata = $random(seed);
    drive_c(a_msg(Release, toN, 3'd2, 32'h0000_4000, 5'd4, 4'h0, '0));
    expect_host_d(d_msg(ReleaseAck, 3'd0, 5'd4, '0), 1'b0, 0);
    host_c_valid_i <= 1'b0;
    drive_c(a_msg(ReleaseData, toN, 3'd2, 32'h0000_4000, 5'd4, 4'h0, wdata));
    expect_dev_a(a_msg(PutFullData, 3'd0, 3'd2, 32'h0000_4000, {3'd4, XactRelData},
                       4'hf, wdata), 1'b0);
    host_c_valid_i <= 1'b0;
    drive_dev_d(d_msg(AccessAck, 3'd0, {3'd4, XactRelData}, '0));
    expect_host_d(d_msg(ReleaseAck, 3'd0, 5'd4, '0), 1'b0, 0);
    dev_d_valid_i <= 1'b0;
  endtask

  // Source 2 sits in host 0's ID range, so only host 1 sees a probe
  task automatic test_put_stall();
    logic [DataWidth-1:0] pdata;
    pdata = $random(seed);
    drive_a(a_msg(PutFullData, 3'd0, 3'd2, 32'h0000_5004, 5'd2, 4'hf, pdata));
    expect_probe(b_msg(toN, 32'h0000_5000, 3'd4));
    drive_c(a_msg(ProbeAck, toN, 3'd2, 32'h0000_5000, 5'd4, 4'h0, '0));
    wait_c_accept();
    expect_dev_a(a_msg(PutFullData, 3'd0, 3'd2, 32'h0000_5004, {3'd2, XactUncached},
                       4'hf, pdata), 1'b1);
    host_a_valid_i <= 1'b0;
    host_d_ready_i <= 1'b0;
    drive_dev_d(d_msg(AccessAck, 3'd0, {3'd2, XactUncached}, '0));
    expect_host_d(d_msg(AccessAck, 3'd0, 5'd2, '0), 1'b0, 4);
    dev_d_valid_i <= 1'b0;
  endtask

  initial begin
    seed           = 32'h8e74;
    rst_ni         = 1'b0;
    host_a_valid_i = 1'b0;
    host_a_i       = '0;
    host_b_ready_i = 1'b1;
    host_c_valid_i = 1'b0;
    host_c_i       = '0;
    host_d_ready_i = 1'b1;
    host_e_valid_i = 1'b0;
    dev_a_ready_i  = 1'b1;
    dev_d_valid_i  = 1'b0;
    dev_d_i        = '0;
    repeat (10) @(posedge clk_i);
    rst_ni <= 1'b1;
    @(negedge clk_i);
    check_bit("host_a_ready_o", host_a_ready_o, 1'b0);
    check_bit("host_b_valid_o", host_b_valid_o, 1'b0);
    check_bit("dev_a_valid_o", dev_a_valid_o, 1'b0);
    check_bit("host_d_valid_o", host_d_valid_o, 1'b0);
    test_uncached_get();
    test_acquire_block();
    test_acquire_perm();
    test_release();
    test_put_stall();
    repeat (5) @(posedge clk_i);
    $display("TB PASSED");
    $finish;
  end

endmodule

//--- source/bcast_hub.sv
`timescale 1ns/1ps

module bcast_hub import bcast_pkg::*; (
  input  logic   clk_i,
  input  logic   rst_ni,
  input  logic   host_a_valid_i,
  input  a_msg_t host_a_i,
  output logic   host_a_ready_o,
  output logic   host_b_valid_o,
  output b_msg_t host_b_o,
  input  logic   host_b_ready_i,
  input  logic   host_c_valid_i,
  input  a_msg_t host_c_i,
  output logic   host_c_ready_o,
  output logic   host_d_valid_o,
  output d_msg_t host_d_o,
  input  logic   host_d_ready_i,
  input  logic   host_e_valid_i,
  output logic   dev_a_valid_o,
  output a_msg_t dev_a_o,
  input  logic   dev_a_ready_i,
  input  logic   dev_d_valid_i,
  input  d_msg_t dev_d_i,
  output logic   dev_d_ready_o
);

  cmd_t                    cmd;
  logic [HostSrcWidth-1:0] cur_source;
  logic [1:0]              probe_ack;
  logic                    grant_done;

  // Device A candidates: 0 host C write-back, 1 host A request
  logic   [1:0] dev_req_valid;
  a_msg_t [1:0] dev_req;
  logic   [1:0] dev_req_ready;

  // Host D candidates: 0 ReleaseAck, 1 Grant, 2 device response
  logic   [2:0] host_rsp_valid;
  d_msg_t [2:0] host_rsp;
  logic   [2:0] host_rsp_ready;

  bcast_decode u_decode (
    .host_a_i         (host_a_i),
    .host_c_valid_i   (host_c_valid_i),
    .host_c_i         (host_c_i),
    .cur_source_i     (cur_source),
    .relack_ready_i   (host_rsp_ready[0]),
    .devreq_ready_i   (dev_req_ready[0]),
    .cmd_o            (cmd),
    .c_probe_ack_o    (probe_ack[0]),
    .c_devreq_valid_o (dev_req_valid[0]),
    .c_devreq_o       (dev_req[0]),
    .relack_valid_o   (host_rsp_valid[0]),
    .relack_o         (host_rsp[0]),
    .host_c_ready_o   (host_c_ready_o)
  );

  // The E channel is always ready and only completes an Acquire
  bcast_txn_ctrl u_txn_ctrl (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .host_a_valid_i (host_a_valid_i),
    .host_a_i       (host_a_i),
    .cmd_i          (cmd),
    .probe_ack_i    (probe_ack),
    .grant_done_i   (grant_done),
    .e_ack_i        (host_e_valid_i),
    .host_a_ready_o (host_a_ready_o),
    .host_b_valid_o (host_b_valid_o),
    .host_b_o       (host_b_o),
    .host_b_ready_i (host_b_ready_i),
    .devreq_valid_o (dev_req_valid[1]),
    .devreq_o       (dev_req[1]),
    .devreq_ready_i (dev_req_ready[1]),
    .grant_valid_o  (host_rsp_valid[1]),
    .grant_o        (host_rsp[1]),
    .grant_ready_i  (host_rsp_ready[1]),
    .cur_source_o   (cur_source)
  );

  bcast_resp_route u_resp_route (
    .dev_d_valid_i (dev_d_valid_i),
    .dev_d_i       (dev_d_i),
    .dev_d_ready_o (dev_d_ready_o),
    .probe_ack_o   (probe_ack[1]),
    .grant_done_o  (grant_done),
    .rsp_valid_o   (host_rsp_valid[2]),
    .rsp_o         (host_rsp[2]),
    .rsp_ready_i   (host_rsp_ready[2])
  );

  bcast_rr_arb #(.NumReq(2), .req_t(a_msg_t)) dev_arb (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .req_valid_i (dev_req_valid),
    .req_i       (dev_req),
    .req_ready_o (dev_req_ready),
    .out_valid_o (dev_a_valid_o),
    .out_o       (dev_a_o),
    .out_ready_i (dev_a_ready_i)
  );

  bcast_rr_arb #(.NumReq(3), .req_t(d_msg_t)) host_arb (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .req_valid_i (host_rsp_valid),
    .req_i       (host_rsp),
    .req_ready_o (host_rsp_ready),
    .out_valid_o (host_d_valid_o),
    .out_o       (host_d_o),
    .out_ready_i (host_d_ready_i)
  );

  a_host_d_known: assert property (@(posedge clk_i) disable iff (!rst_ni)
    host_d_valid_o |-> !$isunknown(host_d_o.opcode));

endmodule

//--- source/bcast_resp_route.sv
`timescale 1ns/1ps

module bcast_resp_route import bcast_pkg::*; (
  input  logic   dev_d_valid_i,
  input  d_msg_t dev_d_i,
  output logic   dev_d_ready_o,
  output logic   probe_ack_o,
  output logic   grant_done_o,
  output logic   rsp_valid_o,
  output d_msg_t rsp_o,
  input  logic   rsp_ready_i
);

  xact_e tag;
  logic  drop;
  logic  completes;

  assign tag = xact_e'(dev_d_i.source[1:0]);

  // Tag 0 carries both write-back acks and GrantData toT
  assign drop = tag == XactProbeAckData && dev_d_i.opcode == AccessAck;

  always_comb begin
    rsp_o.opcode = dev_d_i.opcode;
    rsp_o.param  = '0;
    rsp_o.source = {2'b00, dev_d_i.source[DevSrcWidth-1:2]};
    rsp_o.data   = dev_d_i.data;
    completes    = 1'b0;
    case (tag)
      XactAcqToT: begin
        rsp_o.opcode = GrantData;
        rsp_o.param  = toT;
        completes    = !drop;
      end
      XactAcqToB: begin
        rsp_o.opcode = GrantData;
        rsp_o.param  = toB;
        completes    = 1'b1;
      end
      XactRelData: begin
        rsp_o.opcode = ReleaseAck;
      end
      default: begin
        // Uncached responses keep the device opcode
        completes = 1'b1;
      end
    endcase
  end

  assign rsp_valid_o   = dev_d_valid_i && !drop;
  assign dev_d_ready_o = drop || rsp_ready_i;
  assign probe_ack_o   = dev_d_valid_i && drop;
  assign grant_done_o  = rsp_valid_o && rsp_ready_i && completes;

endmodule

//--- source/bcast_txn_ctrl.sv
`timescale 1ns/1ps

module bcast_txn_ctrl import bcast_pkg::*; (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  logic                    host_a_valid_i,
  input  a_msg_t                  host_a_i,
  input  cmd_t                    cmd_i,
  input  logic [1:0]              probe_ack_i,
  input  logic                    grant_done_i,
  input  logic                    e_ack_i,
  output logic                    host_a_ready_o,
  output logic                    host_b_valid_o,
  output b_msg_t                  host_b_o,
  input  logic                    host_b_ready_i,
  output logic                    devreq_valid_o,
  output a_msg_t                  devreq_o,
  input  logic                    devreq_ready_i,
  output logic                    grant_valid_o,
  output d_msg_t                  grant_o,
  input  logic                    grant_ready_i,
  output logic [HostSrcWidth-1:0] cur_source_o
);

  typedef enum logic [2:0] {Idle, Probe, Req, Grant, Wait} state_e;

  state_e                    state_q, state_d;
  logic [AckCntWidth-1:0]    ack_cnt_q, ack_cnt_d;
  logic [NumCachedHosts-1:0] probe_pend_q, probe_pend_d;
  logic                      grant_done_q, grant_done_d;
  logic                      e_done_q, e_done_d;

  // Transaction payload captured in Idle
  a_op_e                     opcode_q;
  logic [AddrWidth-1:0]      addr_q;
  logic [HostSrcWidth-1:0]   source_q;
  xact_e                     xact_q;
  cap_e                      probe_param_q;
  logic                      direct_q;

  ////////////////////////////////////////////////////////////////////
  // Probe sequencer
  ////////////////////////////////////////////////////////////////////

  logic [NumCachedHosts-1:0] probe_sel;
  logic [HostSrcWidth-1:0]   probe_src;

  // Lowest pending host goes first
  always_comb begin
    probe_sel = '0;
    probe_src = '0;
    for (int i = NumCachedHosts - 1; i >= 0; i--) begin
      if (probe_pend_q[i]) begin
        probe_sel    = '0;
        probe_sel[i] = 1'b1;
        probe_src    = SourceBase[i];
      end
    end
  end

  assign host_b_valid_o   = |probe_pend_q;
  assign host_b_o.param   = probe_param_q;
  assign host_b_o.address = {addr_q[AddrWidth-1:BlockOffset], {BlockOffset{1'b0}}};
  assign host_b_o.source  = probe_src;
  assign cur_source_o     = source_q;

  ////////////////////////////////////////////////////////////////////
  // Transaction FSM
  ////////////////////////////////////////////////////////////////////

  always_comb begin
    state_d      = state_q;
    ack_cnt_d    = ack_cnt_q;
    probe_pend_d = probe_pend_q;
    grant_done_d = grant_done_q || grant_done_i;
    e_done_d     = e_done_q || e_ack_i;

    host_a_ready_o = 1'b0;
    devreq_valid_o = 1'b0;
    grant_valid_o  = 1'b0;

    // Cached requests read the whole beat with a tagged Get
    devreq_o.opcode  = xact_q == XactUncached ? opcode_q : Get;
    devreq_o.param   = xact_q == XactUncached ? host_a_i.param : 3'd0;
    devreq_o.size    = host_a_i.size;
    devreq_o.address = addr_q;
    devreq_o.source  = {source_q, xact_q};
    devreq_o.mask    = host_a_i.mask;
    devreq_o.data    = host_a_i.data;

    // The local Grant state hides the D opcode of the same name
    grant_o.opcode = bcast_pkg::Grant;
    grant_o.param  = xact_q == XactAcqToB ? toB : toT;
    grant_o.source = {2'b00, source_q};
    grant_o.data   = '0;

    if (host_b_valid_o && host_b_ready_i) begin
      probe_pend_d = probe_pend_q & ~probe_sel;
    end

    case (state_q)
      Idle: begin
        if (host_a_valid_i) begin
          probe_pend_d = cmd_i.probe_mask;
          ack_cnt_d    = AckCntWidth'($countones(cmd_i.probe_mask));
          grant_done_d = 1'b0;
          e_done_d     = !cmd_i.need_e_ack;
          state_d      = Probe;
        end
      end
      Probe: begin
        ack_cnt_d = ack_cnt_q - AckCntWidth'(probe_ack_i[0]) - AckCntWidth'(probe_ack_i[1]);
        if (ack_cnt_d == '0) begin
          state_d = direct_q ? Grant : Req;
        end
      end
      Req: begin
        devreq_valid_o = host_a_valid_i;
        host_a_ready_o = devreq_ready_i;
        if (host_a_valid_i && devreq_ready_i) begin
          state_d = Wait;
        end
      end
      Grant: begin
        grant_valid_o  = host_a_valid_i;
        host_a_ready_o = grant_ready_i;
        if (host_a_valid_i && grant_ready_i) begin
          grant_done_d = 1'b1;
          state_d      = Wait;
        end
      end
      Wait: begin
        // Response and E ack may arrive in either order
        if (grant_done_d && e_done_d) begin
          state_d = Idle;
        end
      end
      default: state_d = Idle;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q      <= Idle;
      ack_cnt_q    <= '0;
      probe_pend_q <= '0;
      grant_done_q <= 1'b0;
      e_done_q     <= 1'b0;
    end else begin
      state_q      <= state_d;
      ack_cnt_q    <= ack_cnt_d;
      probe_pend_q <= probe_pend_d;
      grant_done_q <= grant_done_d;
      e_done_q     <= e_done_d;
    end
  end

  always_ff @(posedge clk_i) begin
    if (state_q == Idle && host_a_valid_i) begin
      opcode_q      <= host_a_i.opcode;
      addr_q        <= host_a_i.address;
      source_q      <= host_a_i.source[HostSrcWidth-1:0];
      xact_q        <= cmd_i.xact;
      probe_param_q <= cmd_i.probe_param;
      direct_q      <= cmd_i.direct_grant;
    end
  end

  // Acks only arrive while probing, and never more than are owed
  a_ack_no_underflow: assert property (@(posedge clk_i) disable iff (!rst_ni)
    |probe_ack_i |-> state_q == Probe &&
      ack_cnt_q >= AckCntWidth'($countones(probe_ack_i)));

  a_no_probe_in_idle: assert property (@(posedge clk_i) disable iff (!rst_ni)
    state_q == Idle |-> !host_b_valid_o);

endmodule

//--- source/bcast_decode.sv
`timescale 1ns/1ps

module bcast_decode import bcast_pkg::*; (
  input  a_msg_t                  host_a_i,
  input  logic                    host_c_valid_i,
  input  a_msg_t                  host_c_i,
  input  logic [HostSrcWidth-1:0] cur_source_i,
  input  logic                    relack_ready_i,
  input  logic                    devreq_ready_i,
  output cmd_t                    cmd_o,
  output logic                    c_probe_ack_o,
  output logic                    c_devreq_valid_o,
  output a_msg_t                  c_devreq_o,
  output logic                    relack_valid_o,
  output d_msg_t                  relack_o,
  output logic                    host_c_ready_o
);

  // Byte lanes touched by a single 32-bit beat
  function automatic logic [MaskWidth-1:0] byte_mask(
    input logic [1:0]           addr,
    input logic [SizeWidth-1:0] size
  );
    logic [MaskWidth-1:0] m;
    case (size)
      3'd0:    m = 4'b0001 << addr;
      3'd1:    m = addr[1] ? 4'b1100 : 4'b0011;
      default: m = 4'b1111;
    endcase
    return m;
  endfunction

  ////////////////////////////////////////////////////////////////////
  // Host A classification
  ////////////////////////////////////////////////////////////////////

  logic [NumCachedHosts-1:0] req_hit;

  for (genvar i = 0; i < NumCachedHosts; i++) begin : g_match
    assign req_hit[i] =
      (host_a_i.source[HostSrcWidth-1:0] & ~SourceMask[i]) == SourceBase[i];
  end

  always_comb begin
    cmd_o.xact         = XactUncached;
    cmd_o.probe_param  = toN;
    cmd_o.probe_mask   = ~req_hit;
    cmd_o.direct_grant = host_a_i.opcode == AcquirePerm;
    cmd_o.need_e_ack   = 1'b0;
    case (host_a_i.opcode)
      AcquireBlock, AcquirePerm: begin
        cmd_o.need_e_ack = 1'b1;
        if (host_a_i.param == NtoB) begin
          cmd_o.xact        = XactAcqToB;
          cmd_o.probe_param = toB;
        end else begin
          cmd_o.xact = XactAcqToT;
        end
      end
      Get:     cmd_o.probe_param = toB;
      default: cmd_o.probe_param = toN;
    endcase
  end

  ////////////////////////////////////////////////////////////////////
  // Host C classification
  ////////////////////////////////////////////////////////////////////

  always_comb begin
    c_devreq_o.opcode  = PutFullData;
    c_devreq_o.param   = '0;
    c_devreq_o.size    = host_c_i.size;
    c_devreq_o.address = host_c_i.address;
    c_devreq_o.mask    = byte_mask(host_c_i.address[1:0], host_c_i.size);
    c_devreq_o.data    = host_c_i.data;
    // Probe data is written back under the ID of the request that caused it
    if (host_c_i.opcode == ProbeAckData) begin
      c_devreq_o.source = {cur_source_i, XactProbeAckData};
    end else begin
      c_devreq_o.source = {host_c_i.source[HostSrcWidth-1:0], XactRelData};
    end
  end

  assign relack_o.opcode = ReleaseAck;
  assign relack_o.param  = '0;
  assign relack_o.source = host_c_i.source;
  assign relack_o.data   = '0;

  assign c_probe_ack_o    = host_c_valid_i && host_c_i.opcode == ProbeAck;
  assign c_devreq_valid_o = host_c_valid_i &&
                            (host_c_i.opcode == ProbeAckData || host_c_i.opcode == ReleaseData);
  assign relack_valid_o   = host_c_valid_i && host_c_i.opcode == Release;

  always_comb begin
    if (c_devreq_valid_o) begin
      host_c_ready_o = devreq_ready_i;
    end else if (relack_valid_o) begin
      host_c_ready_o = relack_ready_i;
    end else begin
      host_c_ready_o = c_probe_ack_o;
    end
  end

  always_comb begin
    a_c_opcode: assert final (!host_c_valid_i || host_c_i.opcode inside
      {ProbeAck, ProbeAckData, Release, ReleaseData});
  end

endmodule

//--- source/bcast_rr_arb.sv
`timescale 1ns/1ps

module bcast_rr_arb #(
  parameter int unsigned NumReq = 2,
  parameter type         req_t  = logic
) (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  logic       [NumReq-1:0] req_valid_i,
  input  req_t       [NumReq-1:0] req_i,
  output logic       [NumReq-1:0] req_ready_o,
  output logic                    out_valid_o,
  output req_t                    out_o,
  input  logic                    out_ready_i
);

  logic [$clog2(NumReq)-1:0] ptr_q;
  logic [NumReq-1:0]         grant;
  int unsigned               sel_idx;

  // Search starts at the pointer and wraps around
  always_comb begin
    int unsigned idx;
    grant   = '0;
    sel_idx = 0;
    for (int unsigned k = 0; k < NumReq; k++) begin
      idx = (ptr_q + k) % NumReq;
      if (grant == '0 && req_valid_i[idx]) begin
        grant[idx] = 1'b1;
        sel_idx    = idx;
      end
    end
  end

  assign out_valid_o = |grant;
  assign out_o       = req_i[sel_idx];
  assign req_ready_o = grant & {NumReq{out_ready_i}};

  // Pointer moves past the winner only when its message leaves
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      ptr_q <= '0;
    end else if (out_valid_o && out_ready_i) begin
      ptr_q <= $bits(ptr_q)'((sel_idx + 1) % NumReq);
    end
  end

  a_grant_onehot: assert property (@(posedge clk_i) disable iff (!rst_ni)
    $onehot0(grant));

endmodule

//--- source/bcast_pkg.sv
package bcast_pkg;

  ////////////////////////////////////////////////////////////////////
  // Link widths and host table
  ////////////////////////////////////////////////////////////////////

  localparam int unsigned AddrWidth      = 32;
  localparam int unsigned DataWidth      = 32;
  localparam int unsigned MaskWidth      = 4;
  localparam int unsigned SizeWidth      = 3;
  localparam int unsigned HostSrcWidth   = 3;
  // Host source plus the 2-bit transaction tag
  localparam int unsigned DevSrcWidth    = 5;
  localparam int unsigned NumCachedHosts = 2;
  localparam int unsigned BlockBytes     = 64;
  localparam int unsigned BlockOffset    = $clog2(BlockBytes);
  localparam int unsigned AckCntWidth    = $clog2(NumCachedHosts + 1);

  // Probe source IDs, four IDs per cached host
  localparam logic [NumCachedHosts-1:0][HostSrcWidth-1:0] SourceBase = {3'd4, 3'd0};
  localparam logic [NumCachedHosts-1:0][HostSrcWidth-1:0] SourceMask = {3'd3, 3'd3};

  ////////////////////////////////////////////////////////////////////
  // Opcodes and parameters
  ////////////////////////////////////////////////////////////////////

  // A channel in the low half, C channel in the high half
  typedef enum logic [2:0] {
    PutFullData  = 3'd0,
    Get          = 3'd1,
    AcquireBlock = 3'd2,
    AcquirePerm  = 3'd3,
    ProbeAck     = 3'd4,
    ProbeAckData = 3'd5,
    Release      = 3'd6,
    ReleaseData  = 3'd7
  } a_op_e;

  typedef enum logic [2:0] {
    AccessAck     = 3'd0,
    AccessAckData = 3'd1,
    Grant         = 3'd4,
    GrantData     = 3'd5,
    ReleaseAck    = 3'd6
  } d_op_e;

  typedef enum logic [2:0] {
    toT  = 3'd0,
    toB  = 3'd1,
    toN  = 3'd2,
    NtoB = 3'd3,
    NtoT = 3'd4
  } cap_e;

  // Tag carried in the low device source bits
  typedef enum logic [1:0] {
    XactAcqToT   = 2'd0,
    XactAcqToB   = 2'd1,
    XactRelData  = 2'd2,
    XactUncached = 2'd3
  } xact_e;

  // Shares its code with AcquireBlock toT, the device opcode tells them apart
  localparam xact_e XactProbeAckData = XactAcqToT;

  ////////////////////////////////////////////////////////////////////
  // Channel payloads
  ////////////////////////////////////////////////////////////////////

  typedef struct packed {
    a_op_e                  opcode;
    logic [2:0]             param;
    logic [SizeWidth-1:0]   size;
    logic [AddrWidth-1:0]   address;
    logic [DevSrcWidth-1:0] source;
    logic [MaskWidth-1:0]   mask;
    logic [DataWidth-1:0]   data;
  } a_msg_t;

  typedef struct packed {
    cap_e                    param;
    logic [AddrWidth-1:0]    address;
    logic [HostSrcWidth-1:0] source;
  } b_msg_t;

  typedef struct packed {
    d_op_e                  opcode;
    logic [2:0]             param;
    logic [DevSrcWidth-1:0] source;
    logic [DataWidth-1:0]   data;
  } d_msg_t;

  typedef struct packed {
    xact_e                     xact;
    cap_e                      probe_param;
    logic [NumCachedHosts-1:0] probe_mask;
    logic                      direct_grant;
    logic                      need_e_ack;
  } cmd_t;

endpackage
